// File: hdl/mandel_pkg.sv
// mandelbrot maths definitions
// fixed-point format, iteration limit, starting view and navigation modes
package mandel_pkg;

    // fixed-point format, signed integer bits plus fraction
    localparam int FP_WIDTH = 25;  // total width
    localparam int FP_INT   = 4;   // integer bits incl. sign
    localparam int FP_FRAC  = FP_WIDTH - FP_INT;  // 21 fraction bits

    typedef logic signed [FP_WIDTH-1:0] fp_t;

    // escape-time iteration limit
    localparam int ITER_MAX = 255;
    typedef logic [$clog2(ITER_MAX+1)-1:0] iter_t;  // 8 bits

    // starting view for 16x8 pixels: x -2.5..1.25, y -1.0..0.75
    localparam fp_t X_START  = -fp_t'(5) <<< (FP_FRAC - 1);  // -2.5
    localparam fp_t Y_START  = -fp_t'(1) <<< FP_FRAC;        // -1.0
    localparam fp_t STEP_MAX = fp_t'(1) <<< (FP_FRAC - 2);   // 1/4, also the widest zoom

    // pan distance is step << MOVE_SHIFT
    localparam int MOVE_SHIFT = 2;  // four pixels

    // what up/down act on
    typedef enum logic [1:0] {
        HORIZONTAL,
        VERTICAL,
        ZOOM
    } view_mode_t;

endpackage

// File: hdl/fb_pkg.sv
// framebuffer definitions
// size, address and colour index types, address pipeline depth
package fb_pkg;

    localparam int FB_WIDTH  = 16;  // pixels per line
    localparam int FB_HEIGHT = 8;   // lines
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    typedef logic [$clog2(FB_PIXELS)-1:0] fb_addr_t;  // 7 bits
    typedef logic [3:0] coord_t;  // pixel x or y
    typedef logic [7:0] cidx_t;   // colour index, same value as iteration count

    // cycles from draw to memory write enable
    localparam int ADDR_LAT = 3;

endpackage

// File: hdl/view_control.sv
// view control for the mandelbrot renderer
// button strobes pan or zoom the view, new views are checked then rendered
module view_control import mandel_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_sys,
    input  logic       btn_mode,  // cycle navigation mode
    input  logic       btn_up,
    input  logic       btn_dn,
    input  logic       busy,      // renderer running
    output logic       start,     // one-cycle render request
    output fp_t        x_start,   // left edge
    output fp_t        y_start,   // top edge
    output fp_t        step,      // per-pixel step
    output view_mode_t mode
);

    fp_t  x_start_p, y_start_p, step_p;  // candidate view
    logic changed_params;  // candidate waiting for commit
    logic render_required; // committed view not yet rendered
    logic accept;          // buttons are listened to
    fp_t  move;            // pan distance

    always_comb begin
        accept = !busy && !changed_params;
        move   = step <<< MOVE_SHIFT;
    end

    // candidate view, only loaded on an accepted strobe
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            x_start_p <= x_start;  // unchanged unless a move below
            y_start_p <= y_start;
            step_p    <= step;
            case (mode)
                HORIZONTAL: begin
                    if (btn_up) x_start_p <= x_start - move;       // left
                    else if (btn_dn) x_start_p <= x_start + move;  // right
                end
                VERTICAL: begin
                    if (btn_up) y_start_p <= y_start - move;       // up
                    else if (btn_dn) y_start_p <= y_start + move;  // down
                end
                ZOOM: begin
                    if (btn_up) begin  // zoom out, keep centre
                        x_start_p <= x_start - (step <<< 3);
                        y_start_p <= y_start - (step <<< 2);
                        step_p    <= step <<< 1;
                    end else if (btn_dn) begin  // zoom in, keep centre
                        x_start_p <= x_start + (step <<< 2);
                        y_start_p <= y_start + (step <<< 1);
                        step_p    <= step >>> 1;
                    end
                end
                default: ;
            endcase
        end
    end

    // mode FSM, commit and render request
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            mode            <= HORIZONTAL;
            x_start         <= X_START;
            y_start         <= Y_START;
            step            <= STEP_MAX;
            changed_params  <= 1'b0;
            render_required <= 1'b1;  // draw the default view after reset
            start           <= 1'b0;
        end else begin
            if (accept) begin
                if (btn_up || btn_dn) changed_params <= 1'b1;
                if (btn_mode) begin
                    case (mode)
                        HORIZONTAL: mode <= VERTICAL;
                        VERTICAL:   mode <= ZOOM;
                        default:    mode <= HORIZONTAL;
                    endcase
                end
            end

            start <= 1'b0;
            if (changed_params && !busy) begin
                changed_params <= 1'b0;
                // refuse zooming too far either way
                if (step_p != '0 && step_p <= STEP_MAX) begin
                    x_start         <= x_start_p;
                    y_start         <= y_start_p;
                    step            <= step_p;
                    render_required <= 1'b1;
                end
            end else if (render_required) begin
                start           <= 1'b1;
                render_required <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/mandel_iter.sv
// escape-time iteration core
// iterates z = z^2 + c from z = 0, one step per cycle, returns the count
module mandel_iter import mandel_pkg::*; (
    input  logic  clk_sys,
    input  logic  rst_sys,
    input  logic  iter_start,  // load c and begin
    input  fp_t   cx,
    input  fp_t   cy,
    output logic  iter_done,   // count valid, one cycle
    output iter_t count
);

    fp_t  cx_r, cy_r;  // latched point
    fp_t  x, y;        // current z
    logic running;

    logic signed [2*FP_WIDTH-1:0] xx_full, yy_full, xy_full;
    fp_t  xx, yy, xy;  // products back in fp format
    logic stop;        // escaped or out of iterations
    logic advance;

    always_comb begin
        xx_full = x * x;
        yy_full = y * y;
        xy_full = x * y;
        // arithmetic shift by FP_FRAC then truncate
        xx = xx_full[FP_FRAC +: FP_WIDTH];
        yy = yy_full[FP_FRAC +: FP_WIDTH];
        xy = xy_full[FP_FRAC +: FP_WIDTH];
        stop = ((xx + yy) > (fp_t'(4) <<< FP_FRAC)) || (count == iter_t'(ITER_MAX));
        advance = running && !stop;
    end

    // z datapath
    always_ff @(posedge clk_sys) begin
        if (iter_start) begin
            cx_r <= cx;
            cy_r <= cy;
            x    <= '0;
            y    <= '0;
        end else if (advance) begin
            x <= xx - yy + cx_r;        // re: x^2 - y^2 + cx
            y <= (xy <<< 1) + cy_r;     // im: 2xy + cy
        end
    end

    // control and count
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            running   <= 1'b0;
            iter_done <= 1'b0;
            count     <= '0;
        end else begin
            iter_done <= 1'b0;
            if (iter_start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (advance) begin
                count <= count + 1'b1;
            end else if (running) begin  // stop condition hit
                running   <= 1'b0;
                iter_done <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/render_scan.sv
// framebuffer scanner
// walks the pixels in raster order, runs the iteration core on each one
// and emits a draw strobe per result
module render_scan import mandel_pkg::*, fb_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_sys,
    input  logic   start,
    input  fp_t    x_start,
    input  fp_t    y_start,
    input  fp_t    step,
    output logic   busy,
    output logic   done,  // picture finished, one cycle
    output logic   draw,  // px/py/cidx valid
    output coord_t px,
    output coord_t py,
    output cidx_t  cidx
);

    typedef enum logic [1:0] {IDLE, WAIT, DRAIN} scan_state_t;
    scan_state_t state;

    fp_t    x0, step_r;  // latched view
    fp_t    cx, cy;      // running coordinates
    coord_t col, row;    // current pixel
    logic   iter_start;
    logic   iter_done;
    iter_t  count;
    logic   load;        // accept a new render
    logic   pix_done;    // result back for current pixel
    logic   last_pix;
    logic [$clog2(ADDR_LAT+1)-1:0] drain_cnt;  // waits out store latency

    always_comb begin
        load     = (state == IDLE) && start;
        pix_done = (state == WAIT) && iter_done;
        last_pix = (col == coord_t'(FB_WIDTH-1)) && (row == coord_t'(FB_HEIGHT-1));
    end

    mandel_iter mandel_iter_inst (
        .clk_sys,
        .rst_sys,
        .iter_start,
        .cx,
        .cy,
        .iter_done,
        .count
    );

    // coordinates and draw payload
    always_ff @(posedge clk_sys) begin
        if (load) begin
            x0     <= x_start;
            step_r <= step;
            cx     <= x_start;
            cy     <= y_start;
            col    <= '0;
            row    <= '0;
        end else if (pix_done) begin
            px   <= col;
            py   <= row;
            cidx <= cidx_t'(count);
            if (col == coord_t'(FB_WIDTH-1)) begin  // next line
                col <= '0;
                row <= row + 1'b1;
                cx  <= x0;
                cy  <= cy + step_r;
            end else begin
                col <= col + 1'b1;
                cx  <= cx + step_r;
            end
        end
    end

    // scan FSM
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state      <= IDLE;
            busy       <= 1'b0;
            done       <= 1'b0;
            draw       <= 1'b0;
            iter_start <= 1'b0;
            drain_cnt  <= '0;
        end else begin
            done       <= 1'b0;
            draw       <= 1'b0;
            iter_start <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    busy       <= 1'b1;
                    iter_start <= 1'b1;  // first pixel (0,0)
                    state      <= WAIT;
                end
                WAIT: if (iter_done) begin
                    draw <= 1'b1;
                    if (last_pix) begin
                        drain_cnt <= '0;
                        state     <= DRAIN;
                    end else begin
                        iter_start <= 1'b1;  // cx/cy step on the same edge
                    end
                end
                DRAIN: begin
                    if (int'(drain_cnt) == ADDR_LAT) begin  // last write is in memory
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= IDLE;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: hdl/fb_store.sv
// framebuffer store
// three-stage address pipeline for writes, simple dual-port memory,
// registered read port
module fb_store import fb_pkg::*; (
    input  logic     clk_sys,
    input  logic     rst_sys,
    input  logic     draw,
    input  coord_t   px,
    input  coord_t   py,
    input  cidx_t    cidx,
    input  fb_addr_t rd_addr,
    output cidx_t    rd_data  // word at rd_addr, one cycle later
);

    cidx_t mem [FB_PIXELS];

    logic [ADDR_LAT-1:0] we_sr;    // draw delayed through the pipe
    cidx_t    cidx_d [ADDR_LAT];   // colour delayed alongside
    coord_t   x1, y1;              // stage 1
    coord_t   x2;                  // stage 2
    fb_addr_t row_base;            // stage 2, py * width
    fb_addr_t addr_wr;             // stage 3
    logic     we;

    always_comb we = we_sr[ADDR_LAT-1];

    // write enable shift, control only
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            we_sr <= '0;
        end else begin
            we_sr <= {we_sr[ADDR_LAT-2:0], draw};
        end
    end

    // address pipeline
    always_ff @(posedge clk_sys) begin
        x1       <= px;
        y1       <= py;
        row_base <= fb_addr_t'(y1 * FB_WIDTH);
        x2       <= x1;
        addr_wr  <= row_base + fb_addr_t'(x2);
        cidx_d[0] <= cidx;
        for (int i = 1; i < ADDR_LAT; i++) begin
            cidx_d[i] <= cidx_d[i-1];
        end
    end

    // memory write port
    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_wr] <= cidx_d[ADDR_LAT-1];
    end

    // read port, independent of writes
    always_ff @(posedge clk_sys) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hdl/mandel_top.sv
// mandelbrot renderer top level
// view control feeds the scanner, which draws into the framebuffer
module mandel_top import mandel_pkg::*, fb_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst_sys,
    input  logic       btn_mode,
    input  logic       btn_up,
    input  logic       btn_dn,
    input  fb_addr_t   rd_addr,
    output cidx_t      rd_data,
    output logic       busy,
    output logic       done,
    output view_mode_t mode
);

    logic   start;
    fp_t    x_start, y_start, step;  // current view
    logic   draw;
    coord_t px, py;
    cidx_t  cidx;

    view_control view_control_inst (
        .clk_sys,
        .rst_sys,
        .btn_mode,
        .btn_up,
        .btn_dn,
        .busy,
        .start,
        .x_start,
        .y_start,
        .step,
        .mode
    );

    render_scan render_scan_inst (
        .clk_sys,
        .rst_sys,
        .start,
        .x_start,
        .y_start,
        .step,
        .busy,
        .done,
        .draw,
        .px,
        .py,
        .cidx
    );

    fb_store fb_store_inst (
        .clk_sys,
        .rst_sys,
        .draw,
        .px,
        .py,
        .cidx,
        .rd_addr,
        .rd_data
    );

endmodule

// File: testbench/mandel_model.svh
// reference model for the mandelbrot renderer
// view navigation, bit-exact escape-time count and the expected picture
`ifndef MANDEL_MODEL_SVH
`define MANDEL_MODEL_SVH

fp_t        m_x;     // left edge
fp_t        m_y;     // top edge
fp_t        m_step;  // per-pixel step
view_mode_t m_mode;
cidx_t      m_pic [FB_PIXELS];  // expected framebuffer, raster order

// low FP_WIDTH bits as a signed fixed-point value
function automatic fp_t to_fp(longint v);
    return fp_t'(v);
endfunction

// iterations of z = z^2 + c from z = 0 before |z|^2 passes 4.0
function automatic cidx_t escape_count(fp_t cx, fp_t cy);
    longint x, y, xx, yy, xy;
    int     n;
    x = 0;
    y = 0;
    n = 0;
    while (n < ITER_MAX) begin
        xx = to_fp((x * x) >>> FP_FRAC);  // products back to FP_WIDTH bits
        yy = to_fp((y * y) >>> FP_FRAC);
        xy = to_fp((x * y) >>> FP_FRAC);
        if (to_fp(xx + yy) > 4 * (longint'(1) << FP_FRAC)) break;  // escaped
        x = to_fp(xx - yy + cx);
        y = to_fp(2 * xy + cy);
        n++;
    end
    return cidx_t'(n);
endfunction

// expected picture of the current model view
function automatic void build_picture();
    for (int r = 0; r < FB_HEIGHT; r++) begin
        for (int c = 0; c < FB_WIDTH; c++) begin
            m_pic[r*FB_WIDTH + c] = escape_count(to_fp(m_x + longint'(c) * m_step),
                                                 to_fp(m_y + longint'(r) * m_step));
        end
    end
endfunction

// view after reset
function automatic void reset_view();
    m_x    = X_START;
    m_y    = Y_START;
    m_step = STEP_MAX;
    m_mode = HORIZONTAL;
    build_picture();
endfunction

// one accepted strobe, returns 1 when a new view is committed and drawn
function automatic bit navigate(bit b_mode, bit b_up, bit b_dn);
    longint nx, ny, ns, pan;
    nx  = m_x;
    ny  = m_y;
    ns  = m_step;
    pan = longint'(m_step) << MOVE_SHIFT;  // four pixels
    case (m_mode)
        HORIZONTAL: nx = b_up ? nx - pan : (b_dn ? nx + pan : nx);
        VERTICAL:   ny = b_up ? ny - pan : (b_dn ? ny + pan : ny);
        ZOOM: begin
            if (b_up) begin  // out, centre kept
                nx = nx - 8 * ns;
                ny = ny - 4 * ns;
                ns = 2 * ns;
            end else if (b_dn) begin  // in
                nx = nx + 4 * ns;
                ny = ny + 2 * ns;
                ns = ns >>> 1;
            end
        end
        default: ;
    endcase
    // mode moves on even when the view is refused
    if (b_mode) begin
        case (m_mode)
            HORIZONTAL: m_mode = VERTICAL;
            VERTICAL:   m_mode = ZOOM;
            default:    m_mode = HORIZONTAL;
        endcase
    end
    if (!(b_up || b_dn) || ns == 0 || ns > STEP_MAX) return 1'b0;
    m_x    = to_fp(nx);
    m_y    = to_fp(ny);
    m_step = to_fp(ns);
    build_picture();
    return 1'b1;
endfunction

`endif

// File: testbench/tb_mandel_top.sv
// testbench for the mandelbrot renderer
// random button strobes, waits for each picture and reads the framebuffer back
module tb_mandel_top import mandel_pkg::*, fb_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_PAN      = 10;  // random pans
    localparam int N_ZOOM     = 6;   // random zooms
    localparam int N_BUSY     = 3;   // renders with strobes during busy
    localparam int ZOOM_STEPS = $clog2(STEP_MAX);  // halvings down to a step of 1
    localparam int RENDERS    = 1 + N_PAN + N_ZOOM + ZOOM_STEPS + N_BUSY;
    localparam longint LIMIT_NS = longint'(RENDERS + 2) * FB_PIXELS * (ITER_MAX + 4) * 40;

    logic       clk_sys = 1'b0;
    logic       rst_sys;
    logic       btn_mode;
    logic       btn_up;
    logic       btn_dn;
    fb_addr_t   rd_addr;
    cidx_t      rd_data;
    logic       busy;
    logic       done;
    view_mode_t mode;
    integer     seed = 32'h151f_61d0;

    always #20 clk_sys = ~clk_sys;  // 40 ns period

    mandel_top DUT (
        .clk_sys,
        .rst_sys,
        .btn_mode,
        .btn_up,
        .btn_dn,
        .rd_addr,
        .rd_data,
        .busy,
        .done,
        .mode
    );

    `include "mandel_model.svh"

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_cidx(string name, cidx_t exp, cidx_t act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %0d, got %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_mode(view_mode_t exp, view_mode_t act);
        if (act !== exp) begin
            $display("Error at time %0t: mode expected %0d (%s), got %0d",
                     $time, exp, exp.name(), act);
            stop_run();
        end
    endtask

    task automatic check_flag(string name, bit exp, logic act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    // whole framebuffer against the model at one address per cycle
    task automatic read_picture();
        for (int a = 0; a < FB_PIXELS; a++) begin
            rd_addr = fb_addr_t'(a);
            @(negedge clk_sys);
            check_cidx($sformatf("rd_data[%0d]", a), m_pic[a], rd_data);
        end
    endtask

    task automatic wait_done();
        while (done !== 1'b1) @(negedge clk_sys);
        check_flag("busy", 1'b0, busy);  // falls with done
        @(negedge clk_sys);
        check_flag("done", 1'b0, done);  // single-cycle pulse
    endtask

    // one strobe cycle while idle followed by the picture or the refusal
    task automatic press_buttons(bit b_mode, bit b_up, bit b_dn);
        bit render;
        btn_mode = b_mode;
        btn_up   = b_up;
        btn_dn   = b_dn;
        render   = navigate(b_mode, b_up, b_dn);
        @(negedge clk_sys);
        btn_mode = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
        check_mode(m_mode, mode);
        if (render) begin
            wait_done();
        end else if (b_up || b_dn) begin
            // refused view draws nothing
            repeat (20) begin
                @(negedge clk_sys);
                check_flag("busy", 1'b0, busy);  // no render started
                check_flag("done", 1'b0, done);
            end
        end
        if (b_up || b_dn) read_picture();
    endtask

    // accepted pan followed by random strobes while busy is high
    task automatic pan_with_busy_noise();
        int r;
        r      = $random(seed);
        btn_up = r[0];
        btn_dn = !r[0];
        void'(navigate(1'b0, r[0], !r[0]));
        @(negedge clk_sys);
        btn_up = 1'b0;
        btn_dn = 1'b0;
        while (done !== 1'b1) begin
            @(negedge clk_sys);
            r        = $random(seed);
            btn_mode = busy && r[0];
            btn_up   = busy && r[1];
            btn_dn   = busy && r[2];
        end
        wait_done();
        check_mode(m_mode, mode);  // noise must not move the mode
        read_picture();
    endtask

    initial begin
        #(LIMIT_NS);
        $display("rendering never finished within %0d ns", LIMIT_NS);
        stop_run();
    end

    initial begin
        int r;
        rst_sys  = 1'b1;
        btn_mode = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
        rd_addr  = '0;
        reset_view();
        repeat (8) begin
            @(negedge clk_sys);
            check_flag("busy", 1'b0, busy);
            check_mode(HORIZONTAL, mode);
        end
        rst_sys = 1'b0;
        // default view is drawn without any button
        wait_done();
        read_picture();

        // pans with the mode kept between horizontal and vertical
        repeat (N_PAN) begin
            r = $random(seed);
            if (m_mode == VERTICAL && r[3]) begin
                press_buttons(1'b1, 1'b0, 1'b0);  // via zoom back to horizontal
                press_buttons(1'b1, 1'b0, 1'b0);
            end
            press_buttons(m_mode == HORIZONTAL && r[2], r[0], !r[0]);
        end

        while (m_mode != ZOOM) press_buttons(1'b1, 1'b0, 1'b0);
        press_buttons(1'b0, 1'b1, 1'b0);  // out beyond the widest step
        repeat (N_ZOOM) begin
            r = $random(seed);
            press_buttons(1'b0, r[0], !r[0]);
        end
        while (m_step > 1) press_buttons(1'b0, 1'b0, 1'b1);
        press_buttons(1'b0, 1'b0, 1'b1);  // step would become zero

        while (m_mode != HORIZONTAL) press_buttons(1'b1, 1'b0, 1'b0);
        repeat (N_BUSY) pan_with_busy_noise();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+testbench
hdl/mandel_pkg.sv
hdl/fb_pkg.sv
hdl/view_control.sv
hdl/mandel_iter.sv
hdl/render_scan.sv
hdl/fb_store.sv
hdl/mandel_top.sv
testbench/tb_mandel_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mandelbrot renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
        --top-module tb_mandel_top -Mdir obj_dir -o tb_mandel_top -f src.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_mandel_top)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
